// ==== dv/intr_test_sva.sv ====
// Bound into intr_req_engine; relies on its internal last_id_q and on start winning over a handshake
`timescale 1ns/100ps
`default_nettype none

module intr_req_sva
(
    input  wire logic                    clk,
    input  wire logic                    reset_n,
    input  wire logic                    start,
    input  wire logic                    intr_req_valid,
    input  wire host_chan_pkg::intr_req_t intr_req,
    input  wire logic                    intr_req_ready,
    input  wire host_chan_pkg::intr_id_t last_id_q
);

    import host_chan_pkg::*;

    // Number of assertion failures seen so far
    int fail_count;

    // ==================================================
    // Request channel rules
    // ==================================================

    // A stalled request stays on the channel unchanged
    // A start in the same cycle replaces it with ID 0, so that case is left out
    req_hold_a: assert property (@(posedge clk) disable iff (!reset_n)
        (intr_req_valid && !intr_req_ready && !start) |=> (intr_req_valid && $stable(intr_req)))
    else
    begin
        $error("Request changed or dropped while the host held it off");
        fail_count++;
    end

    // Nothing is offered in the cycle after a reset edge
    reset_quiet_a: assert property (@(posedge clk) !reset_n |=> !intr_req_valid)
    else
    begin
        $error("Request valid seen right after reset");
        fail_count++;
    end

    // The run never walks past its own last ID
    id_range_a: assert property (@(posedge clk) disable iff (!reset_n)
        intr_req_valid |-> (intr_req.id <= last_id_q))
    else
    begin
        $error("Request ID went past the last ID of the run");
        fail_count++;
    end

endmodule

bind intr_req_engine intr_req_sva u_intr_req_sva
(
    .clk            (clk),
    .reset_n        (reset_n),
    .start          (start),
    .intr_req_valid (intr_req_valid),
    .intr_req       (intr_req),
    .intr_req_ready (intr_req_ready),
    .last_id_q      (last_id_q)
);

`default_nettype wire

// ==== dv/intr_test_tb.sv ====
// Host model answers every request 3 cycles after transfer; MMIO tasks expect ready to rise after reset
`timescale 1ns/100ps
`default_nettype none

`include "intr_test_params.svh"

module intr_test_tb;

    import mmio_pkg::*;
    import host_chan_pkg::*;

    localparam int WAIT_LIMIT = 300;

    logic         clk = 1'b0;
    logic         reset_n;
    mmio_wr_t     mmio_wr;
    logic         mmio_wr_valid;
    logic         mmio_wr_ready;
    mmio_rd_req_t mmio_rd;
    logic         mmio_rd_valid;
    logic         mmio_rd_ready;
    logic         mmio_rd_rsp_valid;
    mmio_rd_rsp_t mmio_rd_rsp;
    logic         intr_req_valid;
    intr_req_t    intr_req;
    logic         intr_req_ready;
    logic         intr_resp_valid;
    intr_resp_t   intr_resp;

    // Host ready mode is 0 for random ready, 1 for ready held low and 2 for ready held high
    int           ready_mode = 2;
    logic [31:0]  lcg_state = 32'h99d3_9d7b;
    logic         req_taken;
    logic [2:0]   pipe_valid = '0;
    intr_id_t     pipe_id [3];
    intr_id_t     acc_ids [$];
    int           acc_total = 0;
    int           resp_sent = 0;
    csr_data_t    rd_data;

    intr_test_afu u_intr_test_afu
    (
        .clk (clk), .reset_n (reset_n),
        .mmio_wr (mmio_wr), .mmio_wr_valid (mmio_wr_valid), .mmio_wr_ready (mmio_wr_ready),
        .mmio_rd (mmio_rd), .mmio_rd_valid (mmio_rd_valid), .mmio_rd_ready (mmio_rd_ready),
        .mmio_rd_rsp_valid (mmio_rd_rsp_valid), .mmio_rd_rsp (mmio_rd_rsp),
        .intr_req_valid (intr_req_valid), .intr_req (intr_req),
        .intr_req_ready (intr_req_ready),
        .intr_resp_valid (intr_resp_valid), .intr_resp (intr_resp)
    );

    always #5 clk = ~clk;

    // ==================================================
    // Checks and helpers
    // ==================================================

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Register 3 after a full run to ID n holds n+1 responses and the low n+1 mask bits
    function automatic csr_data_t run_status(input int n);
        return ((64'd1 << (n + 1)) - 64'd1) << 8 | 64'(n + 1);
    endfunction

    task automatic check_value(input string name, input csr_data_t exp, input csr_data_t act);
        assert (act === exp)
        else
        begin
            $display("Error: %s expected %h actual %h", name, exp, act);
            $display("Result: FAILED");
            $fatal(1, "Check %s failed", name);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Gave up waiting for %s", what);
        $display("Result: FAILED");
        $fatal(1, "Timeout on %s", what);
    endtask

    // A bound assertion failure stops the run at the next falling edge
    always @(negedge clk)
    begin
        if (u_intr_test_afu.u_intr_req_engine.u_intr_req_sva.fail_count != 0)
        begin
            $display("Request channel assertion failed");
            $display("Result: FAILED");
            $fatal(1, "Request channel assertion failed");
        end
    end

    // ==================================================
    // Host model
    // ==================================================

    // Ready is chosen first, so valid and ready here are what the next rising edge samples
    always @(negedge clk)
    begin
        lcg_state = lcg_next(lcg_state);
        if (ready_mode == 0)
            intr_req_ready = lcg_state[16];
        else
            intr_req_ready = (ready_mode == 2);
        req_taken = reset_n && intr_req_valid && intr_req_ready;
        if (req_taken)
        begin
            check_value("request interrupt flag", 64'd1, 64'(intr_req.intr));
            acc_ids.push_back(intr_req.id);
            acc_total++;
        end
        // Three stages so the response lands three edges after the transfer
        intr_resp_valid = pipe_valid[2];
        intr_resp.id    = pipe_id[2];
        if (pipe_valid[2])
            resp_sent++;
        pipe_valid = {pipe_valid[1:0], req_taken};
        pipe_id[2] = pipe_id[1];
        pipe_id[1] = pipe_id[0];
        pipe_id[0] = intr_req.id;
    end

    // ==================================================
    // MMIO and wait tasks
    // ==================================================

    task automatic mmio_write(input csr_idx_t idx, input csr_data_t data);
        int t;
        @(negedge clk);
        mmio_wr.idx   = idx;
        mmio_wr.data  = data;
        mmio_wr_valid = 1'b1;
        for (t = 0; !mmio_wr_ready; t++)
        begin
            if (t == WAIT_LIMIT)
                timeout_fail("MMIO write ready");
            @(negedge clk);
        end
        @(negedge clk);
        mmio_wr_valid = 1'b0;
    endtask

    // Data must show in exactly the cycle after the accepting edge
    task automatic read_expect(input string name, input csr_idx_t idx, input csr_data_t exp);
        int t;
        @(negedge clk);
        mmio_rd.idx   = idx;
        mmio_rd_valid = 1'b1;
        for (t = 0; !mmio_rd_ready; t++)
        begin
            if (t == WAIT_LIMIT)
                timeout_fail("MMIO read ready");
            @(negedge clk);
        end
        @(negedge clk);
        mmio_rd_valid = 1'b0;
        check_value({name, " response valid"}, 64'd1, 64'(mmio_rd_rsp_valid));
        rd_data = mmio_rd_rsp.data;
        check_value(name, exp, rd_data);
        @(negedge clk);
        check_value({name, " single response"}, 64'd0, 64'(mmio_rd_rsp_valid));
    endtask

    task automatic wait_req_valid(input logic level);
        int t;
        for (t = 0; intr_req_valid !== level; t++)
        begin
            if (t == WAIT_LIMIT)
                timeout_fail("request valid level");
            @(negedge clk);
        end
    endtask

    // Host bookkeeping moves on falling edges, so these waits step on rising ones
    task automatic wait_accepted(input int n);
        int t;
        for (t = 0; acc_ids.size() < n; t++)
        begin
            if (t == WAIT_LIMIT)
                timeout_fail("accepted requests");
            @(posedge clk);
        end
    endtask

    task automatic wait_responses();
        int t;
        for (t = 0; resp_sent != acc_total; t++)
        begin
            if (t == WAIT_LIMIT)
                timeout_fail("host responses");
            @(posedge clk);
        end
    endtask

    task automatic set_ready_mode(input int mode);
        @(posedge clk);
        ready_mode = mode;
        acc_ids.delete();
    endtask

    task automatic check_ids(input string name, input int n);
        check_value({name, " count"}, 64'(n + 1), 64'(acc_ids.size()));
        for (int i = 0; i <= n; i++)
            check_value($sformatf("%s id %0d", name, i), 64'(i), 64'(acc_ids[i]));
    endtask

    // ==================================================
    // Test sequence
    // ==================================================

    initial
    begin
        reset_n         = 1'b0;
        mmio_wr         = '0;
        mmio_wr_valid   = 1'b0;
        mmio_rd         = '0;
        mmio_rd_valid   = 1'b0;
        intr_req_ready  = 1'b0;
        intr_resp_valid = 1'b0;
        intr_resp       = '0;
        repeat (2) @(negedge clk);
        // Both MMIO channels hold off while reset is applied
        check_value("reset wr ready", 64'd0, 64'(mmio_wr_ready));
        check_value("reset rd ready", 64'd0, 64'(mmio_rd_ready));
        reset_n = 1'b1;

        // Reset state
        check_value("reset req valid", 64'd0, 64'(intr_req_valid));
        check_value("reset rsp valid", 64'd0, 64'(mmio_rd_rsp_valid));
        read_expect("reset status", 4'd3, 64'd0);
        read_expect("reset busy", 4'd4, 64'd0);

        // Identity and configuration
        read_expect("id low", 4'd0, `INTR_TEST_ID_LO);
        read_expect("id high", 4'd1, `INTR_TEST_ID_HI);
        read_expect("config", 4'd2, (64'(`INTR_NUM_IDS) << 8) | 64'd1);
        read_expect("unmapped", 4'd9, 64'd0);

        // Full run with random back-pressure
        set_ready_mode(0);
        mmio_write(4'd0, 64'd3);
        wait_req_valid(1'b1);
        wait_req_valid(1'b0);
        check_ids("full run", 3);
        read_expect("busy after run", 4'd4, 64'd0);

        // Response accounting, then a new start clears it
        wait_responses();
        set_ready_mode(2);
        mmio_write(4'd0, 64'd1);
        wait_req_valid(1'b1);
        wait_req_valid(1'b0);
        wait_responses();
        read_expect("status n1", 4'd3, run_status(1));
        mmio_write(4'd0, 64'd0);
        wait_req_valid(1'b1);
        wait_req_valid(1'b0);
        wait_responses();
        read_expect("status n0", 4'd3, run_status(0));

        // Restart under a stall once two requests are through
        set_ready_mode(0);
        mmio_write(4'd0, 64'd3);
        wait_accepted(2);
        ready_mode = 1;
        // The stalled run still shows as busy
        read_expect("busy in run", 4'd4, 64'd1);
        mmio_write(4'd0, 64'd2);
        // Start follows the write by one edge and the engine restarts on the next
        repeat (2) @(posedge clk);
        ready_mode = 2;
        acc_ids.delete();
        wait_req_valid(1'b0);
        check_ids("restart", 2);

        if (u_intr_test_afu.u_intr_req_engine.u_intr_req_sva.fail_count == 0)
        begin
            $display("Result: PASSED");
            $finish;
        end
        else
        begin
            $display("Request channel assertions reported failures");
            $display("Result: FAILED");
            $fatal(1, "Request channel assertion failure");
        end
    end

endmodule

`default_nettype wire

// ==== include/intr_test_params.svh ====
// Sizes here are fixed for one engine with four interrupt IDs; changing them needs a matching software build
`ifndef INTR_TEST_PARAMS_SVH
`define INTR_TEST_PARAMS_SVH

// ==================================================
// Interrupt sequencing
// ==================================================

// Number of interrupt IDs the engine can walk through in one run
// The ID, count and mask widths in host_chan_pkg all follow from this
`define INTR_NUM_IDS 4

// ==================================================
// MMIO register port
// ==================================================

// Register index width, enough to reach every register below
`define MMIO_ADDR_W 4

// Every register is a full 64-bit word
`define MMIO_DATA_W 64

// Registers decoded by the CSR block, anything past register 4 reads zero
`define CSR_NUM_REGS 16

// ==================================================
// Identity value
// ==================================================

// Software matches both halves before it trusts the rest of the map
`define INTR_TEST_ID_LO 64'h8c2e_41f7_a9d3_05b6
`define INTR_TEST_ID_HI 64'h5e07_d1c4_3fa8_92e1

`endif

// ==== rtl/host_chan_pkg.sv ====
// Host channel types carry only interrupt traffic; no address, data or burst fields exist
`default_nettype none

`include "intr_test_params.svh"

package host_chan_pkg;

    // ==================================================
    // Interrupt widths
    // ==================================================

    // Interrupt ID, just wide enough for INTR_NUM_IDS values
    typedef logic [$clog2(`INTR_NUM_IDS)-1:0] intr_id_t;

    // Response count needs one extra bit so that a full run fits
    typedef logic [$clog2(`INTR_NUM_IDS):0] intr_cnt_t;

    // One bit per interrupt ID
    typedef logic [`INTR_NUM_IDS-1:0] intr_mask_t;

    // ==================================================
    // Channel payloads
    // ==================================================

    // Request from the engine to the host
    // The interrupt flag marks the write as an interrupt and not a data write
    typedef struct packed {
        logic     intr;
        intr_id_t id;
    } intr_req_t;

    // Response from the host, one per accepted request
    // The host never stalls it, so the channel has valid and no ready
    typedef struct packed {
        intr_id_t id;
    } intr_resp_t;

endpackage

`default_nettype wire

// ==== rtl/intr_req_engine.sv ====
// One request per ID from 0 to last_id; a start while a request waits replaces it with ID 0
`timescale 1ns/100ps
`default_nettype none

module intr_req_engine
(
    input  wire logic                    clk,
    input  wire logic                    reset_n,

    // Run control from the CSR block
    input  wire logic                    start,
    input  wire host_chan_pkg::intr_id_t last_id,

    // Host request channel
    output logic                         intr_req_valid,
    output host_chan_pkg::intr_req_t     intr_req,
    input  wire logic                    intr_req_ready,

    // High for the whole run
    output logic                         engine_busy
);

    import mmio_pkg::*;
    import host_chan_pkg::*;

    engine_state_t state;

    // ID of the request on the channel now
    intr_id_t      cur_id;

    // Final ID of this run, latched at start
    intr_id_t      last_id_q;

    // ISSUE means a request is offered on every cycle
    logic          issuing;

    // ==================================================
    // Sequencing FSM
    // ==================================================

    // Start wins over a handshake in the same cycle, which is how a restart works
    // Otherwise each accepted request moves to the next ID on the next edge
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= IDLE;
        end
        else if (start)
        begin
            state <= ISSUE;
        end
        else if ((state == ISSUE) && intr_req_ready && (cur_id == last_id_q))
        begin
            // The last request just went out
            state <= IDLE;
        end
    end

    // ID registers hold no control meaning outside ISSUE
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            cur_id    <= '0;
            last_id_q <= last_id;
        end
        else if (issuing && intr_req_ready)
        begin
            cur_id <= cur_id + 1'b1;
        end
    end

    // ==================================================
    // Request channel
    // ==================================================

    assign issuing = (state == ISSUE);

    // Valid and busy come straight from the state, so both drop on the edge after the last handshake
    assign intr_req_valid = issuing;
    assign engine_busy    = issuing;

    // Every request is an interrupt
    assign intr_req.intr = 1'b1;
    assign intr_req.id   = cur_id;

endmodule

`default_nettype wire

// ==== rtl/intr_resp_tracker.sv ====
// Mask bits follow arrival order rather than the returned ID; count stops at INTR_NUM_IDS
`timescale 1ns/100ps
`default_nettype none

`include "intr_test_params.svh"

module intr_resp_tracker
(
    input  wire logic                      clk,
    input  wire logic                      reset_n,

    // Clears the results at the same edge the engine restarts
    input  wire logic                      start,

    // Host response channel, valid only
    input  wire logic                      intr_resp_valid,
    input  wire host_chan_pkg::intr_resp_t intr_resp,

    // Results read back through register 3
    output host_chan_pkg::intr_cnt_t       resp_count,
    output host_chan_pkg::intr_mask_t      resp_mask
);

    import host_chan_pkg::*;

    // Set once every ID has been answered, later responses are dropped
    logic resp_full;

    // ==================================================
    // Response accounting
    // ==================================================

    assign resp_full = (resp_count == intr_cnt_t'(`INTR_NUM_IDS));

    // The host answers in request order, so the n-th response marks bit n
    // The ID on the channel is kept on the port for the host side and
    // carries no extra meaning here
    always_ff @(posedge clk)
    begin
        if (!reset_n || start)
        begin
            resp_count <= '0;
            resp_mask  <= '0;
        end
        else if (intr_resp_valid && !resp_full)
        begin
            resp_mask[resp_count[$bits(intr_id_t)-1:0]] <= 1'b1;
            resp_count <= resp_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/intr_test_afu.sv ====
// Single clock and single engine; MMIO never stalls and the host response channel cannot be held off
`timescale 1ns/100ps
`default_nettype none

module intr_test_afu
(
    input  wire logic                      clk,
    input  wire logic                      reset_n,

    // MMIO write channel
    input  wire mmio_pkg::mmio_wr_t        mmio_wr,
    input  wire logic                      mmio_wr_valid,
    output logic                           mmio_wr_ready,

    // MMIO read channel
    input  wire mmio_pkg::mmio_rd_req_t    mmio_rd,
    input  wire logic                      mmio_rd_valid,
    output logic                           mmio_rd_ready,
    output logic                           mmio_rd_rsp_valid,
    output mmio_pkg::mmio_rd_rsp_t         mmio_rd_rsp,

    // Host request channel
    output logic                           intr_req_valid,
    output host_chan_pkg::intr_req_t       intr_req,
    input  wire logic                      intr_req_ready,

    // Host response channel
    input  wire logic                      intr_resp_valid,
    input  wire host_chan_pkg::intr_resp_t intr_resp
);

    import host_chan_pkg::*;

    // Run control from the CSR block
    logic       start;
    intr_id_t   last_id;

    // Status returned to the CSR block
    logic       engine_busy;
    intr_cnt_t  resp_count;
    intr_mask_t resp_mask;

    // ==================================================
    // Register file
    // ==================================================

    mmio_csr_mgr u_mmio_csr_mgr
    (
        .clk               (clk),
        .reset_n           (reset_n),
        .mmio_wr           (mmio_wr),
        .mmio_wr_valid     (mmio_wr_valid),
        .mmio_wr_ready     (mmio_wr_ready),
        .mmio_rd           (mmio_rd),
        .mmio_rd_valid     (mmio_rd_valid),
        .mmio_rd_ready     (mmio_rd_ready),
        .mmio_rd_rsp_valid (mmio_rd_rsp_valid),
        .mmio_rd_rsp       (mmio_rd_rsp),
        .start             (start),
        .last_id           (last_id),
        .engine_busy       (engine_busy),
        .resp_count        (resp_count),
        .resp_mask         (resp_mask)
    );

    // ==================================================
    // Request engine and response tracker
    // ==================================================

    intr_req_engine u_intr_req_engine
    (
        .clk            (clk),
        .reset_n        (reset_n),
        .start          (start),
        .last_id        (last_id),
        .intr_req_valid (intr_req_valid),
        .intr_req       (intr_req),
        .intr_req_ready (intr_req_ready),
        .engine_busy    (engine_busy)
    );

    // Shares the start pulse, so results and requests restart together
    intr_resp_tracker u_intr_resp_tracker
    (
        .clk             (clk),
        .reset_n         (reset_n),
        .start           (start),
        .intr_resp_valid (intr_resp_valid),
        .intr_resp       (intr_resp),
        .resp_count      (resp_count),
        .resp_mask       (resp_mask)
    );

endmodule

`default_nettype wire

// ==== rtl/mmio_csr_mgr.sv ====
// Writes are captured a cycle before decode so start lags the write by two edges; no error responses
`timescale 1ns/100ps
`default_nettype none

`include "intr_test_params.svh"

module mmio_csr_mgr
(
    input  wire logic                      clk,
    input  wire logic                      reset_n,

    // MMIO write channel
    input  wire mmio_pkg::mmio_wr_t        mmio_wr,
    input  wire logic                      mmio_wr_valid,
    output logic                           mmio_wr_ready,

    // MMIO read channel
    input  wire mmio_pkg::mmio_rd_req_t    mmio_rd,
    input  wire logic                      mmio_rd_valid,
    output logic                           mmio_rd_ready,
    output logic                           mmio_rd_rsp_valid,
    output mmio_pkg::mmio_rd_rsp_t         mmio_rd_rsp,

    // Run control to the engine
    output logic                           start,
    output host_chan_pkg::intr_id_t        last_id,

    // Status back from the engine and the tracker
    input  wire logic                      engine_busy,
    input  wire host_chan_pkg::intr_cnt_t  resp_count,
    input  wire host_chan_pkg::intr_mask_t resp_mask
);

    import mmio_pkg::*;
    import host_chan_pkg::*;

    // Shared ready for both MMIO channels
    logic      csr_ready;

    // Captured write, decoded on the following edge
    logic      wr_q_valid;
    mmio_wr_t  wr_q;

    // Read view of every register
    csr_data_t csr_regs [`CSR_NUM_REGS];

    // ==================================================
    // Channel ready
    // ==================================================

    // Ready is low only while reset is held, then both channels accept every cycle
    // Software never sees back-pressure on MMIO
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            csr_ready <= 1'b0;
        else
            csr_ready <= 1'b1;
    end

    assign mmio_wr_ready = csr_ready;
    assign mmio_rd_ready = csr_ready;

    // ==================================================
    // Write capture and start decode
    // ==================================================

    // First stage holds the accepted write for one cycle
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            wr_q_valid <= 1'b0;
        else
            wr_q_valid <= mmio_wr_valid && csr_ready;
    end

    // The write payload needs no reset, it is qualified by wr_q_valid
    always_ff @(posedge clk)
    begin
        wr_q <= mmio_wr;
    end

    // Only register 0 is writable and any write there starts a run
    // The pulse is a single cycle, a second write during a run restarts it
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            start <= 1'b0;
        else
            start <= wr_q_valid && (wr_q.idx == '0);
    end

    // Last ID rides in the low bits of the write data, upper bits are ignored
    always_ff @(posedge clk)
    begin
        if (wr_q_valid && (wr_q.idx == '0))
            last_id <= wr_q.data[$bits(intr_id_t)-1:0];
    end

    // ==================================================
    // Register map and read response
    // ==================================================

    // Registers 0 and 1 hold the identity, 2 the configuration, 3 and 4 status
    always_comb
    begin
        for (int i = 0; i < `CSR_NUM_REGS; i++)
        begin
            csr_regs[i] = '0;
        end

        csr_regs[0] = `INTR_TEST_ID_LO;
        csr_regs[1] = `INTR_TEST_ID_HI;
        // Number of IDs above a version byte of 1
        csr_regs[2] = csr_data_t'({8'(`INTR_NUM_IDS), 8'd1});
        // Response mask above the response count
        csr_regs[3] = csr_data_t'({16'(resp_mask), 8'(resp_count)});
        csr_regs[4] = csr_data_t'(engine_busy);
    end

    // Response valid follows an accepted read by exactly one cycle
    always_ff @(posedge clk)
    begin
        if (!reset_n)
            mmio_rd_rsp_valid <= 1'b0;
        else
            mmio_rd_rsp_valid <= mmio_rd_valid && csr_ready;
    end

    // Read data is sampled with the request, so status is as of that edge
    always_ff @(posedge clk)
    begin
        mmio_rd_rsp.data <= csr_regs[mmio_rd.idx];
    end

endmodule

`default_nettype wire

// ==== rtl/mmio_pkg.sv ====
// MMIO types assume one 64-bit word per register index and no byte enables
`default_nettype none

`include "intr_test_params.svh"

package mmio_pkg;

    // ==================================================
    // Register port vectors
    // ==================================================

    // Register index as carried on both MMIO channels
    typedef logic [`MMIO_ADDR_W-1:0] csr_idx_t;

    // One full register word
    typedef logic [`MMIO_DATA_W-1:0] csr_data_t;

    // ==================================================
    // Channel payloads
    // ==================================================

    // A write always covers the whole register
    typedef struct packed {
        csr_idx_t  idx;
        csr_data_t data;
    } mmio_wr_t;

    // A read request names only the register
    typedef struct packed {
        csr_idx_t idx;
    } mmio_rd_req_t;

    // Read data returned one cycle after the request is taken
    typedef struct packed {
        csr_data_t data;
    } mmio_rd_rsp_t;

    // Engine control state, software sees it as the busy bit in register 4
    typedef enum logic [0:0] {
        IDLE,
        ISSUE
    } engine_state_t;

endpackage

`default_nettype wire

// ==== vlog.f ====
+incdir+include
rtl/mmio_pkg.sv
rtl/host_chan_pkg.sv
rtl/mmio_csr_mgr.sv
rtl/intr_req_engine.sv
rtl/intr_resp_tracker.sv
rtl/intr_test_afu.sv
dv/intr_test_sva.sv
dv/intr_test_tb.sv
